// File: tb.f
+incdir+include
source/cache_pkg.sv
source/req_decode.sv
source/way_store.sv
source/hit_execute.sv
source/resp_result.sv
source/cache_bank_top.sv
sim/cache_bank_tb.sv

// File: sim/cache_bank_tb.sv
// cache bank directed testbench
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_bank_tb;
    import cache_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    cache_req_t  req = '0;
    logic        req_valid = 1'b0;
    logic        req_ready;
    cache_resp_t resp;
    logic        resp_valid;
    logic        resp_ready = 1'b1;
    evict_t      evict;
    logic        evict_valid;
    logic        evict_ready = 1'b0;
    miss_req_t   miss;
    logic        miss_valid;
    logic        miss_ready = 1'b0;
    fill_t       fill = '0;
    logic        fill_valid = 1'b0;
    logic        fill_ready;

    integer seed = 32'ha0b6_832a;
    int     edge_cnt = 0;
    int     err_cnt = 0;
    int     to_cnt = 0;
    int     n_checks = 0;

    // memory responder state
    logic [27:0] fill_addr = '0;
    int          fill_wait = 0;
    logic        fill_pend = 1'b0;
    logic        fill_taken = 1'b0;

    // reference model of tags, data and round-robin pointers
    tag_meta_t   m_tag [`CB_SETS][`CB_WAYS];
    line_t       m_line [`CB_SETS][`CB_WAYS];
    logic [1:0]  m_rr [`CB_SETS];

    cache_resp_t exp_resp[$];
    cache_resp_t got_resp[$];
    miss_req_t   exp_miss[$];
    miss_req_t   got_miss[$];
    evict_t      exp_evict[$];
    evict_t      got_evict[$];
    int          got_edge[$];

    cache_bank_top i_dut (
        .clk(clk), .rst(rst),
        .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .resp(resp), .resp_valid(resp_valid), .resp_ready(resp_ready),
        .evict(evict), .evict_valid(evict_valid), .evict_ready(evict_ready),
        .miss(miss), .miss_valid(miss_valid), .miss_ready(miss_ready),
        .fill(fill), .fill_valid(fill_valid), .fill_ready(fill_ready)
    );

    always #20 clk = ~clk;

    always @(posedge clk) edge_cnt++;

    // memory contents, every word depends on the full line address
    function automatic line_t line_at(input logic [27:0] laddr);
        line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = {laddr, 2'(w), 2'b01} ^ 32'h5a5a_5a5a;
        end
        return l;
    endfunction

    function automatic logic [31:0] make_addr(input logic [23:0] tg, input logic [3:0] ix,
                                              input logic [1:0] wd);
        return {tg, ix, wd, 2'b00};
    endfunction

    // sample at negedge, drive 2 ns after posedge
    always @(negedge clk) begin
        if (!rst) begin
            if (evict_valid && evict_ready) begin
                got_evict.push_back(evict);
            end
            if (miss_valid && miss_ready) begin
                got_miss.push_back(miss);
                fill_addr = miss.addr;
                fill_wait = $unsigned($random(seed)) % 5;
                fill_pend = 1'b1;
            end
            if (fill_valid && fill_ready) begin
                fill_taken = 1'b1;
            end
            if (resp_valid && resp_ready) begin
                got_resp.push_back(resp);
                got_edge.push_back(edge_cnt + 1);
            end
        end
        @(posedge clk);
        #2;
        evict_ready = ($random(seed) & 3) != 0;
        miss_ready  = ($random(seed) & 3) != 0;
        if (fill_taken) begin
            fill_valid = 1'b0;
            fill_taken = 1'b0;
        end
        if (fill_pend) begin
            if (fill_wait == 0) begin
                fill.line  = line_at(fill_addr);
                fill_valid = 1'b1;
                fill_pend  = 1'b0;
            end else begin
                fill_wait--;
            end
        end
    end

    task automatic model_reset();
        for (int s = 0; s < `CB_SETS; s++) begin
            m_rr[s] = '0;
            for (int w = 0; w < `CB_WAYS; w++) begin
                m_tag[s][w]  = '0;
                m_line[s][w] = '0;
            end
        end
    endtask

    // predict response and memory traffic for one accepted request
    task automatic model_apply(input cache_req_t r);
        logic [23:0] tg;
        logic [3:0]  ix;
        int          wd;
        int          way;
        logic        hit;
        logic        free;
        cache_resp_t e;
        evict_t      ev;
        miss_req_t   mr;
        tg   = r.addr[31:8];
        ix   = r.addr[7:4];
        wd   = int'(r.addr[3:2]);
        hit  = 1'b0;
        free = 1'b0;
        way  = 0;
        for (int w = `CB_WAYS-1; w >= 0; w--) begin
            if (m_tag[ix][w].valid && m_tag[ix][w].tag == tg) begin
                hit = 1'b1;
                way = w;
            end
        end
        e.ooo_tag = r.ooo_tag;
        e.rdata   = '0;
        e.hit     = hit && r.op != OP_NOP;
        if (r.op == OP_INV && hit) begin
            if (m_tag[ix][way].dirty) begin
                ev.addr = {tg, ix};
                ev.line = m_line[ix][way];
                exp_evict.push_back(ev);
            end
            m_tag[ix][way].valid = 1'b0;
            m_tag[ix][way].dirty = 1'b0;
        end else if (r.op == OP_LD || r.op == OP_ST) begin
            if (!hit) begin
                for (int w = `CB_WAYS-1; w >= 0; w--) begin
                    if (!m_tag[ix][w].valid) begin
                        free = 1'b1;
                        way  = w;
                    end
                end
                if (!free) begin
                    way = m_rr[ix];
                    m_rr[ix]++;
                end
                if (m_tag[ix][way].valid && m_tag[ix][way].dirty) begin
                    ev.addr = {m_tag[ix][way].tag, ix};
                    ev.line = m_line[ix][way];
                    exp_evict.push_back(ev);
                end
                mr.addr = {tg, ix};
                exp_miss.push_back(mr);
                m_line[ix][way] = line_at({tg, ix});
                m_tag[ix][way]  = '{valid: 1'b1, dirty: 1'b0, tag: tg};
            end
            if (r.op == OP_ST) begin
                m_line[ix][way][wd*32 +: 32] = r.wdata;
                m_tag[ix][way].dirty = 1'b1;
            end else begin
                e.rdata = m_line[ix][way][wd*32 +: 32];
            end
        end
        exp_resp.push_back(e);
    endtask

    task automatic compare_resp(input string name, input cache_resp_t exp,
                                input cache_resp_t act);
        n_checks++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %0t %s exp tag=%h rdata=%h hit=%b act tag=%h rdata=%h hit=%b",
                     $time, name, exp.ooo_tag, exp.rdata, exp.hit,
                     act.ooo_tag, act.rdata, act.hit);
        end
    endtask

    task automatic compare_miss(input miss_req_t exp, input miss_req_t act);
        n_checks++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %0t miss.addr exp %h act %h", $time, exp.addr, act.addr);
        end
    endtask

    task automatic compare_evict(input evict_t exp, input evict_t act);
        n_checks++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %0t evict exp %h/%h act %h/%h", $time, exp.addr, exp.line,
                     act.addr, act.line);
        end
    endtask

    task automatic present_req(input op_t op, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [7:0] tag);
        req.op      = op;
        req.addr    = addr;
        req.wdata   = wdata;
        req.ooo_tag = tag;
        req_valid   = 1'b1;
    endtask

    task automatic wait_accept(output int acc_edge);
        int   n;
        logic taken;
        n        = 0;
        taken    = 1'b0;
        acc_edge = -1;
        while (!taken && n < WAIT_LIMIT) begin
            @(negedge clk);
            taken = req_ready;
            @(posedge clk);
            n++;
        end
        #2;
        if (taken) begin
            acc_edge = edge_cnt;
            model_apply(req);
        end else begin
            to_cnt++;
            $display("%0t: request was never accepted", $time);
        end
        req_valid = 1'b0;
    endtask

    task automatic send(input op_t op, input logic [31:0] addr, input logic [31:0] wdata,
                        input logic [7:0] tag, output int acc_edge);
        present_req(op, addr, wdata, tag);
        wait_accept(acc_edge);
    endtask

    task automatic wait_resps();
        int n;
        n = 0;
        while (got_resp.size() < exp_resp.size() && n < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (got_resp.size() < exp_resp.size()) begin
            to_cnt++;
            $display("%0t: response did not arrive in time", $time);
        end
    endtask

    task automatic check_latency(input int acc_edge, input int idx);
        n_checks++;
        if (idx >= got_edge.size()) begin
            err_cnt++;
            $display("%0t: no response to time for request %0d", $time, idx);
        end else if (got_edge[idx] != acc_edge + 2) begin
            err_cnt++;
            $display("ERR %0t resp_edge exp %0d act %0d", $time, acc_edge + 2, got_edge[idx]);
        end
    endtask

    // idle a little so that duplicates show up, then compare everything
    task automatic check_all();
        wait_resps();
        repeat (3) begin
            @(posedge clk);
            #2;
        end
        if (got_resp.size() != exp_resp.size() || got_miss.size() != exp_miss.size()
                || got_evict.size() != exp_evict.size()) begin
            err_cnt++;
            $display("%0t: saw %0d/%0d/%0d responses/misses/evictions, expected %0d/%0d/%0d",
                     $time, got_resp.size(), got_miss.size(), got_evict.size(),
                     exp_resp.size(), exp_miss.size(), exp_evict.size());
        end
        while (got_resp.size() > 0 && exp_resp.size() > 0) begin
            compare_resp("resp", exp_resp.pop_front(), got_resp.pop_front());
        end
        while (got_miss.size() > 0 && exp_miss.size() > 0) begin
            compare_miss(exp_miss.pop_front(), got_miss.pop_front());
        end
        while (got_evict.size() > 0 && exp_evict.size() > 0) begin
            compare_evict(exp_evict.pop_front(), got_evict.pop_front());
        end
        exp_resp.delete();
        got_resp.delete();
        exp_miss.delete();
        got_miss.delete();
        exp_evict.delete();
        got_evict.delete();
        got_edge.delete();
    endtask

    task automatic cold_load();
        int acc;
        send(OP_LD, make_addr(24'h000123, 4'h1, 2'd2), 32'h0, 8'h01, acc);
        check_all();
    endtask

    task automatic warm_load();
        int acc [3];
        send(OP_LD, make_addr(24'h000123, 4'h1, 2'd2), 32'h0, 8'h02, acc[0]);
        wait_resps();
        check_latency(acc[0], 0);
        check_all();
        // one response per cycle
        send(OP_LD, make_addr(24'h000123, 4'h1, 2'd0), 32'h0, 8'h03, acc[0]);
        send(OP_LD, make_addr(24'h000123, 4'h1, 2'd1), 32'h0, 8'h04, acc[1]);
        send(OP_LD, make_addr(24'h000123, 4'h1, 2'd3), 32'h0, 8'h05, acc[2]);
        wait_resps();
        for (int i = 0; i < 3; i++) begin
            check_latency(acc[i], i);
        end
        check_all();
    endtask

    task automatic store_then_load();
        int acc;
        send(OP_ST, make_addr(24'h000123, 4'h1, 2'd1), 32'hdead_beef, 8'h06, acc);
        send(OP_LD, make_addr(24'h000123, 4'h1, 2'd1), 32'h0, 8'h07, acc);
        // store miss installs the fill with the word merged
        send(OP_ST, make_addr(24'h000456, 4'h2, 2'd0), 32'h1234_5678, 8'h08, acc);
        send(OP_LD, make_addr(24'h000456, 4'h2, 2'd0), 32'h0, 8'h09, acc);
        send(OP_LD, make_addr(24'h000456, 4'h2, 2'd3), 32'h0, 8'h0a, acc);
        check_all();
    endtask

    task automatic set_eviction();
        int acc;
        send(OP_LD, make_addr(24'h00a000, 4'h5, 2'd0), 32'h0, 8'h10, acc);
        send(OP_ST, make_addr(24'h00a000, 4'h5, 2'd2), 32'hcafe_f00d, 8'h11, acc);
        send(OP_LD, make_addr(24'h00b000, 4'h5, 2'd1), 32'h0, 8'h12, acc);
        send(OP_LD, make_addr(24'h00c000, 4'h5, 2'd2), 32'h0, 8'h13, acc);
        send(OP_LD, make_addr(24'h00d000, 4'h5, 2'd3), 32'h0, 8'h14, acc);
        send(OP_LD, make_addr(24'h00e000, 4'h5, 2'd0), 32'h0, 8'h15, acc);
        // pointer has moved on, so a clean way goes next
        send(OP_LD, make_addr(24'h00a000, 4'h5, 2'd2), 32'h0, 8'h16, acc);
        check_all();
    endtask

    task automatic invalidate_lines();
        int acc;
        send(OP_ST, make_addr(24'h00e000, 4'h5, 2'd1), 32'h0bad_cafe, 8'h18, acc);
        send(OP_INV, make_addr(24'h00e000, 4'h5, 2'd0), 32'h0, 8'h19, acc);
        send(OP_LD, make_addr(24'h00e000, 4'h5, 2'd1), 32'h0, 8'h1a, acc);
        send(OP_INV, make_addr(24'h00c000, 4'h5, 2'd0), 32'h0, 8'h1b, acc);
        send(OP_INV, make_addr(24'h0beef0, 4'h9, 2'd0), 32'h0, 8'h1c, acc);
        check_all();
    endtask

    task automatic hold_under_backpressure();
        int          acc;
        cache_resp_t held;
        resp_ready = 1'b0;
        send(OP_LD, make_addr(24'h000123, 4'h1, 2'd0), 32'h0, 8'h20, acc);
        send(OP_LD, make_addr(24'h000123, 4'h1, 2'd1), 32'h0, 8'h21, acc);
        present_req(OP_LD, make_addr(24'h000123, 4'h1, 2'd2), 32'h0, 8'h22);
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            if (!resp_valid) begin
                err_cnt++;
                $display("%0t: response dropped while resp_ready was low", $time);
            end
            if (i == 0) begin
                held = resp;
            end else begin
                compare_resp("resp (held)", held, resp);
            end
            if (req_ready) begin
                err_cnt++;
                $display("%0t: req_ready stayed high under back-pressure", $time);
            end
            @(posedge clk);
            #2;
        end
        resp_ready = 1'b1;
        wait_accept(acc);
        check_all();
    endtask

    task automatic end_run();
        $display("checks %0d, errors %0d, timeouts %0d", n_checks, err_cnt, to_cnt);
        if (err_cnt == 0 && to_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    initial begin
        model_reset();
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        cold_load();
        warm_load();
        store_then_load();
        set_eviction();
        invalidate_lines();
        hold_under_backpressure();
        end_run();
    end

endmodule

// File: source/cache_bank_top.sv
// data cache bank top level
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_bank_top (
    input  logic                   clk,
    input  logic                   rst,
    input  cache_pkg::cache_req_t  req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output cache_pkg::cache_resp_t resp,
    output logic                   resp_valid,
    input  logic                   resp_ready,
    output cache_pkg::evict_t      evict,
    output logic                   evict_valid,
    input  logic                   evict_ready,
    output cache_pkg::miss_req_t   miss,
    output logic                   miss_valid,
    input  logic                   miss_ready,
    input  cache_pkg::fill_t       fill,
    input  logic                   fill_valid,
    output logic                   fill_ready
);
    import cache_pkg::*;

    dec_req_t                  dec;
    logic                      dec_valid, dec_ready, rd_en;
    logic [`CB_INDEX_BITS-1:0] rd_index, tag_wr_index, data_wr_index;
    logic [`CB_WAYS-1:0]       tag_wr_way_en, data_wr_way_en;
    tag_meta_t [`CB_WAYS-1:0]  tags;
    line_t [`CB_WAYS-1:0]      lines;
    tag_meta_t                 tag_wr_entry;
    line_t                     data_wr_entry;
    cache_resp_t               exe_resp;
    logic                      exe_valid, exe_ready;

    // arrays read for a new request or to refresh the held one
    assign rd_en = req_valid || dec_valid;

    req_decode i_decode (
        .clk(clk), .rst(rst),
        .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .rd_index(rd_index),
        .dec(dec), .dec_valid(dec_valid), .dec_ready(dec_ready)
    );

    way_store #(.entry_t(tag_meta_t)) i_tag_store (
        .clk(clk), .rst(rst),
        .rd_index(rd_index), .rd_en(rd_en), .rd_ways(tags),
        .wr_index(tag_wr_index), .wr_way_en(tag_wr_way_en), .wr_entry(tag_wr_entry)
    );

    way_store #(.entry_t(line_t)) i_data_store (
        .clk(clk), .rst(rst),
        .rd_index(rd_index), .rd_en(rd_en), .rd_ways(lines),
        .wr_index(data_wr_index), .wr_way_en(data_wr_way_en), .wr_entry(data_wr_entry)
    );

    hit_execute i_execute (
        .clk(clk), .rst(rst),
        .dec(dec), .dec_valid(dec_valid), .dec_ready(dec_ready),
        .tags(tags), .lines(lines),
        .tag_wr_index(tag_wr_index), .tag_wr_way_en(tag_wr_way_en),
        .tag_wr_entry(tag_wr_entry),
        .data_wr_index(data_wr_index), .data_wr_way_en(data_wr_way_en),
        .data_wr_entry(data_wr_entry),
        .evict(evict), .evict_valid(evict_valid), .evict_ready(evict_ready),
        .miss(miss), .miss_valid(miss_valid), .miss_ready(miss_ready),
        .fill(fill), .fill_valid(fill_valid), .fill_ready(fill_ready),
        .exe_resp(exe_resp), .exe_valid(exe_valid), .exe_ready(exe_ready)
    );

    resp_result i_result (
        .clk(clk), .rst(rst),
        .exe_resp(exe_resp), .exe_valid(exe_valid), .exe_ready(exe_ready),
        .resp(resp), .resp_valid(resp_valid), .resp_ready(resp_ready)
    );

endmodule

// File: source/resp_result.sv
// response output register
`timescale 1ns/1ps

module resp_result (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::cache_resp_t exe_resp,
    input  logic                  exe_valid,
    output logic                  exe_ready,
    output cache_pkg::cache_resp_t resp,
    output logic                  resp_valid,
    input  logic                  resp_ready
);
    // one entry, refilled in the same cycle it drains
    assign exe_ready = !resp_valid || resp_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (exe_valid && exe_ready) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid && exe_ready) begin
            resp <= exe_resp;
        end
    end

    a_resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("resp changed under back-pressure");

endmodule

// File: source/hit_execute.sv
// hit/miss engine for one cache bank
`timescale 1ns/1ps
`include "cache_config.svh"

module hit_execute (
    input  logic                                 clk,
    input  logic                                 rst,
    input  cache_pkg::dec_req_t                  dec,
    input  logic                                 dec_valid,
    output logic                                 dec_ready,
    input  cache_pkg::tag_meta_t [`CB_WAYS-1:0]  tags,
    input  cache_pkg::line_t [`CB_WAYS-1:0]      lines,
    output logic [`CB_INDEX_BITS-1:0]            tag_wr_index,
    output logic [`CB_WAYS-1:0]                  tag_wr_way_en,
    output cache_pkg::tag_meta_t                 tag_wr_entry,
    output logic [`CB_INDEX_BITS-1:0]            data_wr_index,
    output logic [`CB_WAYS-1:0]                  data_wr_way_en,
    output cache_pkg::line_t                     data_wr_entry,
    output cache_pkg::evict_t                    evict,
    output logic                                 evict_valid,
    input  logic                                 evict_ready,
    output cache_pkg::miss_req_t                 miss,
    output logic                                 miss_valid,
    input  logic                                 miss_ready,
    input  cache_pkg::fill_t                     fill,
    input  logic                                 fill_valid,
    output logic                                 fill_ready,
    output cache_pkg::cache_resp_t               exe_resp,
    output logic                                 exe_valid,
    input  logic                                 exe_ready
);
    import cache_pkg::*;

    localparam int WAY_BITS = $clog2(`CB_WAYS);

    typedef enum logic [2:0] {S_IDLE, S_EVICT, S_MISS, S_FILL, S_INSTALL} state_t;

    state_t              state;
    logic [WAY_BITS-1:0] rr_ptr [`CB_SETS];
    line_t               fill_line;
    line_t               base_line;
    logic [`CB_WAYS-1:0] hit_vec, way_onehot;
    logic [WAY_BITS-1:0] hit_way, free_way, victim, act_way;
    logic                hit_any, free_found, need_mem, need_evict, go_mem;
    logic                fire, tag_write, data_write;

    function automatic line_t merge_word(line_t line, logic [1:0] word, logic [31:0] data);
        line_t merged;
        merged = line;
        merged[{word, 5'b0} +: 32] = data;
        return merged;
    endfunction

    // descending scan leaves the lowest matching way
    always_comb begin
        hit_any    = 1'b0;
        hit_way    = '0;
        free_found = 1'b0;
        free_way   = '0;
        for (int w = `CB_WAYS-1; w >= 0; w--) begin
            hit_vec[w] = tags[w].valid && (tags[w].tag == dec.tag);
            if (hit_vec[w]) begin
                hit_any = 1'b1;
                hit_way = WAY_BITS'(w);
            end
            if (!tags[w].valid) begin
                free_found = 1'b1;
                free_way   = WAY_BITS'(w);
            end
        end
        way_onehot          = '0;
        way_onehot[act_way] = 1'b1;
    end

    assign victim  = free_found ? free_way : rr_ptr[dec.index];
    assign act_way = hit_any ? hit_way : victim;

    // a miss needs memory, and so does an invalidate of a dirty line
    assign need_mem   = (dec.op == OP_LD || dec.op == OP_ST) && !hit_any;
    assign need_evict = (need_mem || (dec.op == OP_INV && hit_any))
                        && tags[act_way].valid && tags[act_way].dirty;
    assign go_mem     = dec_valid && (need_mem || need_evict);

    assign exe_valid = (state == S_IDLE && dec_valid && !go_mem) || state == S_INSTALL;
    assign fire      = exe_valid && exe_ready;
    assign dec_ready = exe_ready && ((state == S_IDLE && !go_mem) || state == S_INSTALL);

    assign base_line  = (state == S_INSTALL) ? fill_line : lines[act_way];
    assign tag_write  = state == S_INSTALL || dec.op == OP_ST || (dec.op == OP_INV && hit_any);
    assign data_write = dec.op == OP_ST || (state == S_INSTALL && dec.op != OP_INV);

    // array writes land only when the response leaves
    assign tag_wr_index   = dec.index;
    assign tag_wr_way_en  = (fire && tag_write) ? way_onehot : '0;
    assign tag_wr_entry   = '{valid: dec.op != OP_INV, dirty: dec.op == OP_ST, tag: dec.tag};
    assign data_wr_index  = dec.index;
    assign data_wr_way_en = (fire && data_write) ? way_onehot : '0;
    assign data_wr_entry  = (dec.op == OP_ST) ? merge_word(base_line, dec.word, dec.wdata)
                                              : base_line;

    assign exe_resp.ooo_tag = dec.ooo_tag;
    assign exe_resp.rdata   = (dec.op == OP_LD) ? base_line[{dec.word, 5'b0} +: 32] : '0;
    assign exe_resp.hit     = (state == S_IDLE) ? (hit_any && dec.op != OP_NOP)
                                                : (dec.op == OP_INV);

    assign evict.addr  = {tags[act_way].tag, dec.index};
    assign evict.line  = lines[act_way];
    assign evict_valid = state == S_EVICT;
    assign miss.addr   = {dec.tag, dec.index};
    assign miss_valid  = state == S_MISS;
    assign fill_ready  = state == S_FILL;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            for (int s = 0; s < `CB_SETS; s++) begin
                rr_ptr[s] <= '0;
            end
        end else begin
            case (state)
                S_IDLE:    if (go_mem) state <= need_evict ? S_EVICT : S_MISS;
                S_EVICT:   if (evict_ready) state <= (dec.op == OP_INV) ? S_INSTALL : S_MISS;
                S_MISS:    if (miss_ready) state <= S_FILL;
                S_FILL:    if (fill_valid) state <= S_INSTALL;
                S_INSTALL: if (exe_ready) state <= S_IDLE;
                default:   state <= S_IDLE;
            endcase
            // pointer moves only when it picked the victim
            if (fire && state == S_INSTALL && dec.op != OP_INV && !free_found) begin
                rr_ptr[dec.index] <= rr_ptr[dec.index] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid && fill_ready) begin
            fill_line <= fill.line;
        end
    end

    a_single_hit: assert property (@(posedge clk) disable iff (rst)
        dec_valid |-> $onehot0(hit_vec))
        else $error("tag present in more than one way");

    // a pending write-back keeps its address and line
    a_evict_hold: assert property (@(posedge clk) disable iff (rst)
        evict_valid && !evict_ready |=> evict_valid && $stable(evict))
        else $error("evict changed while stalled");

endmodule

// File: source/way_store.sv
// per-way set storage with write bypass
`timescale 1ns/1ps
`include "cache_config.svh"

module way_store #(
    parameter type entry_t = logic [7:0]
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`CB_INDEX_BITS-1:0] rd_index,
    input  logic                      rd_en,
    output entry_t [`CB_WAYS-1:0]     rd_ways,
    input  logic [`CB_INDEX_BITS-1:0] wr_index,
    input  logic [`CB_WAYS-1:0]       wr_way_en,
    input  entry_t                    wr_entry
);
    entry_t mem [`CB_WAYS][`CB_SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `CB_WAYS; w++) begin
                for (int s = 0; s < `CB_SETS; s++) begin
                    mem[w][s] <= '0;
                end
            end
        end else begin
            for (int w = 0; w < `CB_WAYS; w++) begin
                if (wr_way_en[w]) begin
                    mem[w][wr_index] <= wr_entry;
                end
            end
        end
    end

    // synchronous read, a write to the same set this cycle wins
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ways <= '0;
        end else if (rd_en) begin
            for (int w = 0; w < `CB_WAYS; w++) begin
                if (wr_way_en[w] && wr_index == rd_index) begin
                    rd_ways[w] <= wr_entry;
                end else begin
                    rd_ways[w] <= mem[w][rd_index];
                end
            end
        end
    end

    a_one_way_wr: assert property (@(posedge clk) disable iff (rst)
        $onehot0(wr_way_en))
        else $error("more than one way written");

endmodule

// File: source/req_decode.sv
// request intake and address split
`timescale 1ns/1ps
`include "cache_config.svh"

module req_decode (
    input  logic                       clk,
    input  logic                       rst,
    input  cache_pkg::cache_req_t      req,
    input  logic                       req_valid,
    output logic                       req_ready,
    output logic [`CB_INDEX_BITS-1:0]  rd_index,
    output cache_pkg::dec_req_t        dec,
    output logic                       dec_valid,
    input  logic                       dec_ready
);
    logic accept;

    // take a new request when empty or when execute drains the held one
    assign req_ready = !dec_valid || dec_ready;
    assign accept    = req_valid && req_ready;

    // keep the arrays pointed at the held set while stalled
    assign rd_index = accept ? req.addr[`CB_OFFSET_BITS +: `CB_INDEX_BITS] : dec.index;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (accept) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec.op      <= req.op;
            dec.tag     <= req.addr[31 -: `CB_TAG_BITS];
            dec.index   <= req.addr[`CB_OFFSET_BITS +: `CB_INDEX_BITS];
            dec.word    <= req.addr[`CB_OFFSET_BITS-1:2];
            dec.wdata   <= req.wdata;
            dec.ooo_tag <= req.ooo_tag;
        end
    end

    // a stalled source keeps its request
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("req changed while stalled");

endmodule

// File: source/cache_pkg.sv
// cache bank shared types
`include "cache_config.svh"

package cache_pkg;

    typedef enum logic [1:0] {
        OP_NOP,
        OP_LD,
        OP_ST,
        OP_INV
    } op_t;

    // pipeline request as it arrives
    typedef struct packed {
        op_t                     op;
        logic [31:0]             addr;
        logic [31:0]             wdata;
        logic [`CB_OOO_BITS-1:0] ooo_tag;
    } cache_req_t;

    // address already split into tag, set and word
    typedef struct packed {
        op_t                       op;
        logic [`CB_TAG_BITS-1:0]   tag;
        logic [`CB_INDEX_BITS-1:0] index;
        logic [1:0]                word;
        logic [31:0]               wdata;
        logic [`CB_OOO_BITS-1:0]   ooo_tag;
    } dec_req_t;

    typedef struct packed {
        logic                    valid;
        logic                    dirty;
        logic [`CB_TAG_BITS-1:0] tag;
    } tag_meta_t;

    typedef logic [`CB_LINE_BITS-1:0] line_t;

    // rdata is zero unless the op was a load
    typedef struct packed {
        logic [`CB_OOO_BITS-1:0] ooo_tag;
        logic [31:0]             rdata;
        logic                    hit;
    } cache_resp_t;

    // line address is {tag, index}
    typedef struct packed {
        logic [`CB_TAG_BITS+`CB_INDEX_BITS-1:0] addr;
    } miss_req_t;

    typedef struct packed {
        logic [`CB_TAG_BITS+`CB_INDEX_BITS-1:0] addr;
        line_t                                  line;
    } evict_t;

    typedef struct packed {
        line_t line;
    } fill_t;

endpackage

// File: include/cache_config.svh
// data cache bank geometry
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// set and way counts
`define CB_SETS        16
`define CB_WAYS        4

// line layout, 16 bytes per line
`define CB_LINE_BITS   128
`define CB_OFFSET_BITS 4
`define CB_INDEX_BITS  4

// what is left of a 32-bit address
`define CB_TAG_BITS    24

// out-of-order tag carried with each request
`define CB_OOO_BITS    8

`endif
